// File: tb.f
+incdir+design
+incdir+tb
design/htb_pkg.sv
design/huf_tree_builder.sv
design/huf_pipe_arbiter.sv
design/huf_htb_top.sv
tb/tb_huf_htb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the Huffman builder testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal -f tb.f --top-module tb_huf_htb \
   > build.log 2>&1 && ./obj_dir/Vtb_huf_htb > sim.log 2>&1
grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb/huf_ref_model.svh
//####################################################################
// Expected result of one frequency block for the Huffman builder.
// Include inside the testbench module after importing the package.
//####################################################################

`ifndef HUF_REF_MODEL_SVH
`define HUF_REF_MODEL_SVH

// Lightest group first, lowest label on equal weight, merge under the smaller label.
function automatic code_blk_s expected_lengths(input sym_blk_s b, input code_len_t limit);
   int        w [`HTB_NUM_SYM];
   int        grp [`HTB_NUM_SYM];
   bit        live [`HTB_NUM_SYM];
   int        depth [`HTB_NUM_SYM];
   int        n;
   int        a;
   int        c;
   int        lo;
   int        sum;
   code_blk_s r;
   n = 0;
   for (int i = 0; i < `HTB_NUM_SYM; i++)
   begin
      w[i]     = int'(b.freq[i]);
      grp[i]   = i;
      live[i]  = (b.freq[i] != '0);
      depth[i] = 0;
      if (live[i])
         n++;
   end
   if (n == 1)
   begin
      for (int i = 0; i < `HTB_NUM_SYM; i++)
         if (live[i])
            depth[i] = 1;
   end
   for (int step = 1; step < n; step++)
   begin
      a = -1;
      c = -1;
      for (int j = 0; j < `HTB_NUM_SYM; j++)
         if (live[j] && (a < 0 || w[j] < w[a]))
            a = j;
      for (int j = 0; j < `HTB_NUM_SYM; j++)
         if (live[j] && j != a && (c < 0 || w[j] < w[c]))
            c = j;
      lo  = (a < c) ? a : c;
      sum = w[a] + w[c];
      for (int i = 0; i < `HTB_NUM_SYM; i++)
      begin
         if (grp[i] == a || grp[i] == c)
         begin
            depth[i]++;
            grp[i] = lo;
         end
      end
      live[(a < c) ? c : a] = 1'b0;
      w[lo] = sum;
   end
   r.seq_id      = b.seq_id;
   r.build_error = 1'b0;
   for (int i = 0; i < `HTB_NUM_SYM; i++)
   begin
      r.len[i] = code_len_t'(depth[i]);
      if (depth[i] > int'(limit))
         r.build_error = 1'b1;
   end
   return r;
endfunction

`endif

// File: tb/tb_huf_htb.sv
//####################################################################
// Testbench for the two-pipe Huffman code length builder.
// Drives random and directed blocks while assertions check every result.
//####################################################################

`timescale 1ns/1ps

`include "htb_params.svh"

module tb_huf_htb;

   import htb_pkg::*;

   `include "huf_ref_model.svh"

   localparam int NUM_IDS     = 1 << `HTB_SEQ_W;
   localparam int TIMEOUT_CYC = 1000;

   logic      clk;
   logic      rst;
   logic      blk_strobe;
   sym_blk_s  blk;
   logic      disable_second_pipe;
   code_len_t max_code_len;
   logic      out_not_ready;
   logic      blk_not_ready;
   logic      out_valid;
   code_blk_s out_blk;

   code_blk_s exp_blk [NUM_IDS];
   int        sent_cnt [NUM_IDS] = '{default: 0};
   int        recv_cnt [NUM_IDS] = '{default: 0};
   int        sent_total = 0;
   int        recv_total = 0;
   int        stall_mode = 0;

   huf_htb_top UUT
   (
      .clk                 (clk),
      .rst                 (rst),
      .blk_strobe          (blk_strobe),
      .blk                 (blk),
      .disable_second_pipe (disable_second_pipe),
      .max_code_len        (max_code_len),
      .out_not_ready       (out_not_ready),
      .blk_not_ready       (blk_not_ready),
      .out_valid           (out_valid),
      .out_blk             (out_blk)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Stall mode 0 leaves the output free, 1 stalls at random, 2 holds it.
   initial
   begin
      out_not_ready = 1'b0;
      forever
      begin
         @(negedge clk);
         if (stall_mode == 2)
            out_not_ready = 1'b1;
         else if (stall_mode == 1)
            out_not_ready = ($urandom % 3 == 0);
         else
            out_not_ready = 1'b0;
      end
   end

   always @(posedge clk)
   begin
      if (!rst && out_valid)
      begin
         recv_cnt[out_blk.seq_id] <= recv_cnt[out_blk.seq_id] + 1;
         recv_total               <= recv_total + 1;
      end
   end

   a_reset_clear: assert property (@(posedge clk) rst |=> !blk_not_ready && !out_valid)
      else abort_run($sformatf("CHECK FAILED blk_not_ready/out_valid expected 0/0 got %h/%h",
         $sampled(blk_not_ready), $sampled(out_valid)));

   a_known_id: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> sent_cnt[out_blk.seq_id] > recv_cnt[out_blk.seq_id])
      else abort_run($sformatf("Result with seq_id %h was never sent or arrived twice",
         $sampled(out_blk.seq_id)));

   a_len: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> out_blk.len == exp_blk[out_blk.seq_id].len)
      else abort_run($sformatf("CHECK FAILED out_blk.len expected %h got %h",
         exp_blk[$sampled(out_blk.seq_id)].len, $sampled(out_blk.len)));

   a_error: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> out_blk.build_error == exp_blk[out_blk.seq_id].build_error)
      else abort_run($sformatf("CHECK FAILED out_blk.build_error expected %h got %h",
         exp_blk[$sampled(out_blk.seq_id)].build_error, $sampled(out_blk.build_error)));

   a_stall: assert property (@(posedge clk) disable iff (rst) out_not_ready |=> !out_valid)
      else abort_run($sformatf("CHECK FAILED out_valid expected 0 got %h", $sampled(out_valid)));

   // Every enabled pipe holds a block.
   a_full: assert property (@(posedge clk) disable iff (rst)
      (sent_total - recv_total) >= (disable_second_pipe ? 1 : 2) && !out_valid
      |-> blk_not_ready)
      else abort_run($sformatf("CHECK FAILED blk_not_ready expected 1 got %h",
         $sampled(blk_not_ready)));

   function automatic sym_blk_s random_block();
      sym_blk_s b;
      int       r;
      b = '0;
      for (int i = 0; i < `HTB_NUM_SYM; i++)
      begin
         r = $urandom % 8;
         if (r < 2)
            b.freq[i] = '0;
         else if (r < 4 && i > 0)
            b.freq[i] = b.freq[i-1];
         else if (r < 6)
            b.freq[i] = freq_t'(1 + $urandom % 16);
         else
            b.freq[i] = freq_t'($urandom);
      end
      return b;
   endfunction

   // Powers of two give one long chain with a longest length of 7.
   function automatic sym_blk_s skewed_block(input int rot);
      sym_blk_s b;
      b = '0;
      for (int i = 0; i < `HTB_NUM_SYM; i++)
         b.freq[i] = freq_t'(1) << ((i + rot) % `HTB_NUM_SYM);
      return b;
   endfunction

   task automatic send_block(input sym_blk_s b);
      seq_id_t id;
      int      waited;
      id = seq_id_t'($urandom);
      while (sent_cnt[id] != recv_cnt[id])
         id = id + 1'b1;
      waited = 0;
      while (blk_not_ready && waited < TIMEOUT_CYC)
      begin
         @(negedge clk);
         waited++;
      end
      if (blk_not_ready)
         abort_run("Timed out waiting for blk_not_ready to fall");
      b.seq_id    = id;
      blk         = b;
      blk_strobe  = 1'b1;
      exp_blk[id] = expected_lengths(b, max_code_len);
      @(negedge clk);
      blk_strobe   = 1'b0;
      sent_cnt[id] = sent_cnt[id] + 1;
      sent_total   = sent_total + 1;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (sent_total != recv_total && waited < TIMEOUT_CYC)
      begin
         @(negedge clk);
         waited++;
      end
      if (sent_total != recv_total)
         abort_run("Timed out waiting for all results to arrive");
   endtask

   initial
   begin
      sym_blk_s b;
      void'($urandom(1854));
      rst                 = 1'b1;
      blk_strobe          = 1'b0;
      blk                 = '0;
      disable_second_pipe = 1'b0;
      max_code_len        = code_len_t'(15);
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Directed corner cases one at a time.
      b = '0;
      send_block(b);
      wait_drain();
      b.freq[5] = freq_t'(77);
      send_block(b);
      wait_drain();
      b.freq[2] = freq_t'(77);
      send_block(b);
      wait_drain();
      for (int i = 0; i < `HTB_NUM_SYM; i++)
         b.freq[i] = freq_t'(9);
      send_block(b);
      wait_drain();
      b.freq = {freq_t'(3), freq_t'(3), freq_t'(1), freq_t'(1),
                freq_t'(0), freq_t'(2), freq_t'(2), freq_t'(0)};
      send_block(b);
      wait_drain();
      for (int k = 0; k < 10; k++)
      begin
         send_block(random_block());
         wait_drain();
      end

      // Back to back over both pipes with a random output stall.
      stall_mode = 1;
      for (int k = 0; k < 30; k++)
         send_block(random_block());
      wait_drain();
      stall_mode = 0;

      // Single pipe.
      disable_second_pipe = 1'b1;
      for (int k = 0; k < 12; k++)
         send_block(random_block());
      wait_drain();
      disable_second_pipe = 1'b0;

      // Results wait inside the builders while the output is held.
      stall_mode = 2;
      send_block(random_block());
      send_block(random_block());
      repeat (40) @(negedge clk);
      stall_mode = 0;
      wait_drain();

      // Length limit against the skewed chain.
      max_code_len = code_len_t'(3);
      send_block(skewed_block(0));
      wait_drain();
      max_code_len = code_len_t'(7);
      send_block(skewed_block(3));
      wait_drain();
      for (int k = 0; k < 8; k++)
      begin
         max_code_len = code_len_t'(1 + $urandom % 8);
         send_block(($urandom % 2 == 0) ? skewed_block($urandom % 8) : random_block());
         wait_drain();
      end

      if (sent_total == recv_total)
      begin
         $display("TEST PASS");
         $finish;
      end
      else
         abort_run("Results are still missing at the end of the run");
   end

endmodule

// File: design/huf_htb_top.sv
//####################################################################
// Huffman code length builder top level. Two builder pipes behind one
// arbiter that steers input blocks and merges results.
//####################################################################

`timescale 1ns/1ps

module huf_htb_top
(
   input  logic               clk,
   input  logic               rst,
   input  logic               blk_strobe,
   input  htb_pkg::sym_blk_s  blk,
   input  logic               disable_second_pipe,
   input  htb_pkg::code_len_t max_code_len,
   input  logic               out_not_ready,
   output logic               blk_not_ready,
   output logic               out_valid,
   output htb_pkg::code_blk_s out_blk
);

   import htb_pkg::*;

   logic      strobe1;
   logic      strobe2;
   logic      take1;
   logic      take2;
   logic      not_ready1;
   logic      not_ready2;
   logic      done1;
   logic      done2;
   code_blk_s result1;
   code_blk_s result2;

   huf_tree_builder builder1
   (
      .clk          (clk),
      .rst          (rst),
      .strobe       (strobe1),
      .blk_in       (blk),
      .max_code_len (max_code_len),
      .take         (take1),
      .not_ready    (not_ready1),
      .done         (done1),
      .result       (result1)
   );

   huf_tree_builder builder2
   (
      .clk          (clk),
      .rst          (rst),
      .strobe       (strobe2),
      .blk_in       (blk),
      .max_code_len (max_code_len),
      .take         (take2),
      .not_ready    (not_ready2),
      .done         (done2),
      .result       (result2)
   );

   huf_pipe_arbiter arbiter
   (
      .clk                 (clk),
      .rst                 (rst),
      .blk_strobe          (blk_strobe),
      .disable_second_pipe (disable_second_pipe),
      .out_not_ready       (out_not_ready),
      .not_ready1          (not_ready1),
      .not_ready2          (not_ready2),
      .done1               (done1),
      .done2               (done2),
      .result1             (result1),
      .result2             (result2),
      .strobe1             (strobe1),
      .strobe2             (strobe2),
      .take1               (take1),
      .take2               (take2),
      .blk_not_ready       (blk_not_ready),
      .out_valid           (out_valid),
      .out_blk             (out_blk)
   );

endmodule

// File: design/huf_pipe_arbiter.sv
//####################################################################
// Steers incoming blocks to a free builder pipe and merges finished
// results round-robin onto one registered output stream.
//####################################################################

`timescale 1ns/1ps

module huf_pipe_arbiter
(
   input  logic               clk,
   input  logic               rst,
   input  logic               blk_strobe,
   input  logic               disable_second_pipe,
   input  logic               out_not_ready,
   input  logic               not_ready1,
   input  logic               not_ready2,
   input  logic               done1,
   input  logic               done2,
   input  htb_pkg::code_blk_s result1,
   input  htb_pkg::code_blk_s result2,
   output logic               strobe1,
   output logic               strobe2,
   output logic               take1,
   output logic               take2,
   output logic               blk_not_ready,
   output logic               out_valid,
   output htb_pkg::code_blk_s out_blk
);

   // Pipe 2 looks busy while software holds it off.
   logic busy2;

   // Pipe 2 wins the next tie.
   logic pri2;

   assign busy2         = not_ready2 | disable_second_pipe;
   assign blk_not_ready = not_ready1 & busy2;

   // Pipe 1 first, pipe 2 only when pipe 1 is occupied.
   assign strobe1 = blk_strobe & ~not_ready1;
   assign strobe2 = blk_strobe & not_ready1 & ~busy2;

   // Results stay in their builders while the output is stalled.
   assign take1 = ~out_not_ready & done1 & (~done2 | ~pri2);
   assign take2 = ~out_not_ready & done2 & (~done1 | pri2);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pri2      <= 1'b0;
         out_valid <= 1'b0;
      end
      else
      begin
         out_valid <= take1 | take2;
         if (take1)
            pri2 <= 1'b1;
         else if (take2)
            pri2 <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (take1)
         out_blk <= result1;
      else if (take2)
         out_blk <= result2;
   end

   // Each block lands in exactly one pipe.
   a_one_strobe: assert property (@(posedge clk) disable iff (rst)
      !(strobe1 && strobe2));

   // One result per output cycle.
   a_one_take: assert property (@(posedge clk) disable iff (rst)
      !(take1 && take2));

   // Disabled pipe receives no new work.
   a_no_strobe2_off: assert property (@(posedge clk) disable iff (rst)
      disable_second_pipe |-> !strobe2);

endmodule

// File: design/huf_tree_builder.sv
//####################################################################
// One tree-builder pipe. Turns a frequency block into code lengths by
// merging the two lightest groups once per cycle, then holds the result.
//####################################################################

`timescale 1ns/1ps

`include "htb_params.svh"

module huf_tree_builder
(
   input  logic               clk,
   input  logic               rst,
   input  logic               strobe,
   input  htb_pkg::sym_blk_s  blk_in,
   input  htb_pkg::code_len_t max_code_len,
   input  logic               take,
   output logic               not_ready,
   output logic               done,
   output htb_pkg::code_blk_s result
);

   import htb_pkg::*;

   builder_state_e state;

   sym_blk_s blk_q;

   // Per symbol group label and length, per label group weight and live flag.
   sym_idx_t [`HTB_NUM_SYM-1:0]  sym_lbl;
   code_len_t [`HTB_NUM_SYM-1:0] len_q;
   weight_t [`HTB_NUM_SYM-1:0]   grp_w;
   logic [`HTB_NUM_SYM-1:0]      grp_act;
   sym_idx_t                     merge_cnt;

   logic [$clog2(`HTB_NUM_SYM):0] nz_cnt;

   // Lightest and second lightest live groups.
   logic     a_found;
   sym_idx_t a_lbl;
   weight_t  a_w;
   logic     b_found;
   sym_idx_t b_lbl;
   weight_t  b_w;
   sym_idx_t lo_lbl;
   sym_idx_t hi_lbl;

   logic len_err;

   always_comb
   begin
      nz_cnt = '0;
      for (int i = 0; i < `HTB_NUM_SYM; i++)
      begin
         if (blk_q.freq[i] != '0)
            nz_cnt = nz_cnt + 1'b1;
      end
   end

   // Strict compare keeps the lowest label on equal weights.
   always_comb
   begin
      a_found = 1'b0;
      a_lbl   = '0;
      a_w     = '0;
      for (int j = 0; j < `HTB_NUM_SYM; j++)
      begin
         if (grp_act[j] && (!a_found || grp_w[j] < a_w))
         begin
            a_found = 1'b1;
            a_lbl   = sym_idx_t'(j);
            a_w     = grp_w[j];
         end
      end
      b_found = 1'b0;
      b_lbl   = '0;
      b_w     = '0;
      for (int j = 0; j < `HTB_NUM_SYM; j++)
      begin
         if (grp_act[j] && sym_idx_t'(j) != a_lbl && (!b_found || grp_w[j] < b_w))
         begin
            b_found = 1'b1;
            b_lbl   = sym_idx_t'(j);
            b_w     = grp_w[j];
         end
      end
      lo_lbl = (a_lbl < b_lbl) ? a_lbl : b_lbl;
      hi_lbl = (a_lbl < b_lbl) ? b_lbl : a_lbl;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= IDLE;
      else
      begin
         case (state)
            IDLE:
               if (strobe)
                  state <= LOAD;
            LOAD:
               state <= (nz_cnt > 1) ? MERGE : DONE;
            MERGE:
               if (merge_cnt == sym_idx_t'(1))
                  state <= DONE;
            DONE:
               if (take)
                  state <= IDLE;
            default:
               state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (strobe && state == IDLE)
         blk_q <= blk_in;
      case (state)
         LOAD:
         begin
            for (int i = 0; i < `HTB_NUM_SYM; i++)
            begin
               sym_lbl[i] <= sym_idx_t'(i);
               grp_w[i]   <= weight_t'(blk_q.freq[i]);
               grp_act[i] <= (blk_q.freq[i] != '0);
               // A lone symbol still needs one bit.
               len_q[i]   <= (nz_cnt == 1 && blk_q.freq[i] != '0) ? code_len_t'(1) : '0;
            end
            merge_cnt <= sym_idx_t'(nz_cnt - 1'b1);
         end
         MERGE:
         begin
            grp_w[lo_lbl]   <= a_w + b_w;
            grp_act[hi_lbl] <= 1'b0;
            for (int i = 0; i < `HTB_NUM_SYM; i++)
            begin
               if (sym_lbl[i] == a_lbl || sym_lbl[i] == b_lbl)
               begin
                  len_q[i]   <= len_q[i] + 1'b1;
                  sym_lbl[i] <= lo_lbl;
               end
            end
            merge_cnt <= merge_cnt - 1'b1;
         end
         default:
         begin
         end
      endcase
   end

   always_comb
   begin
      len_err = 1'b0;
      for (int i = 0; i < `HTB_NUM_SYM; i++)
      begin
         if (len_q[i] > max_code_len)
            len_err = 1'b1;
      end
   end

   assign not_ready          = (state != IDLE);
   assign done               = (state == DONE);
   assign result.seq_id      = blk_q.seq_id;
   assign result.len         = len_q;
   assign result.build_error = len_err;

   // Arbiter only hands a block to an idle builder.
   a_strobe_idle: assert property (@(posedge clk) disable iff (rst)
      strobe |-> !not_ready);

   // Arbiter only retires a finished result.
   a_take_done: assert property (@(posedge clk) disable iff (rst)
      take |-> done);

endmodule

// File: design/htb_pkg.sv
//####################################################################
// Shared types for the Huffman tree builder pipes and their arbiter.
// Modules name these types by scope in port lists and import in bodies.
//####################################################################

`include "htb_params.svh"

package htb_pkg;

   typedef logic [`HTB_FREQ_W-1:0] freq_t;

   // Room for the sum of every frequency in one block.
   typedef logic [`HTB_FREQ_W+$clog2(`HTB_NUM_SYM)-1:0] weight_t;

   typedef logic [`HTB_LEN_W-1:0] code_len_t;
   typedef logic [`HTB_SEQ_W-1:0] seq_id_t;

   // Symbol index that doubles as a group label.
   typedef logic [$clog2(`HTB_NUM_SYM)-1:0] sym_idx_t;

   typedef struct packed {
      seq_id_t                  seq_id;
      freq_t [`HTB_NUM_SYM-1:0] freq;
   } sym_blk_s;

   typedef struct packed {
      seq_id_t                      seq_id;
      code_len_t [`HTB_NUM_SYM-1:0] len;
      logic                         build_error;
   } code_blk_s;

   typedef enum logic [1:0] {
      IDLE,
      LOAD,
      MERGE,
      DONE
   } builder_state_e;

endpackage

// File: design/htb_params.svh
//####################################################################
// Alphabet size and field widths for the Huffman tree builder.
// Include wherever a width is needed. The package types are built on these.
//####################################################################

`ifndef HTB_PARAMS_SVH
`define HTB_PARAMS_SVH

// Symbols per frequency block.
`define HTB_NUM_SYM 8

// One symbol frequency.
`define HTB_FREQ_W 12

// One code length.
`define HTB_LEN_W 4

// Block sequence id.
`define HTB_SEQ_W 6

`endif
